/* common/slr_shell_pkg.sv */
package slr_shell_pkg;

    // stream widths
    localparam int DATA_W = 64;
    localparam int KEEP_W = DATA_W / 8;
    localparam int USER_W = 4;

    // each crossing FIFO holds 2**FIFO_LOG_DEPTH beats
    localparam int FIFO_LOG_DEPTH = 1;
    localparam int FIFO_DEPTH = 1 << FIFO_LOG_DEPTH;

    // FIFOs between the receive input and the arbiter
    localparam int SLR_STAGE_COUNT = 4;

    // one 77-bit stream beat
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [KEEP_W-1:0] keep;
        logic [USER_W-1:0] user;
        logic              last;
    } axis_beat_t;

    // transmit arbiter
    typedef enum logic {
        ARB_IDLE   = 1'b0,
        ARB_LOCKED = 1'b1
    } arb_state_e;

endpackage

/* run_sim.sh */
#!/bin/sh
# build and run the slr_shell testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log
SIM_BIN=obj_dir/slr_shell_sim

verilator --binary --timing --assert \
    --top-module slr_shell_tb \
    -o slr_shell_sim \
    -f slr_shell.f > "$BUILD_LOG" 2>&1
build_status=$?
if [ $build_status -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "build failed with status $build_status"
    exit 1
fi

"$SIM_BIN" +verilator+error+limit+100 > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulator exited with status $sim_status"
    exit 1
fi

if grep -q "^Result: PASSED$" "$SIM_LOG"; then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed, see $SIM_LOG"
exit 1

/* slr_crossing/slr_crossing.sv */
`timescale 1ns/100ps

module slr_crossing import slr_shell_pkg::*; (
     input  logic       clk
    ,input  logic       arst_n

    ,input  axis_beat_t in_beat
    ,input  logic       in_valid
    ,output logic       in_ready

    ,output axis_beat_t out_beat
    ,output logic       out_valid
    ,input  logic       out_ready
);

    // link i feeds stage i, link i+1 leaves it
    axis_beat_t                 link_beat  [SLR_STAGE_COUNT+1];
    logic [SLR_STAGE_COUNT:0]   link_valid;
    logic [SLR_STAGE_COUNT:0]   link_ready;

    assign link_beat[0]  = in_beat;
    assign link_valid[0] = in_valid;
    assign in_ready      = link_ready[0];

    assign out_beat                    = link_beat[SLR_STAGE_COUNT];
    assign out_valid                   = link_valid[SLR_STAGE_COUNT];
    assign link_ready[SLR_STAGE_COUNT] = out_ready;

    // each hop drains into the next as soon as the next has room
    genvar i;
    generate
        for (i = 0; i < SLR_STAGE_COUNT; i++) begin : g_stage
            axis_fifo stage_fifo (
                 .clk       (clk                )
                ,.arst_n    (arst_n             )

                ,.wr_beat   (link_beat[i]       )
                ,.wr_valid  (link_valid[i]      )
                ,.wr_ready  (link_ready[i]      )

                ,.rd_beat   (link_beat[i+1]     )
                ,.rd_valid  (link_valid[i+1]    )
                ,.rd_ready  (link_ready[i+1]    )
            );
        end
    endgenerate

endmodule

/* slr_shell.f */
common/slr_shell_pkg.sv
verilog/axis_fifo.sv
slr_crossing/slr_crossing.sv
tx_arb_mux/tx_arb_mux.sv
verilog/slr_shell_top.sv
test/slr_shell_properties.sv
test/slr_shell_tb.sv

/* test/slr_shell_properties.sv */
`timescale 1ns/100ps

module slr_shell_properties import slr_shell_pkg::*; (
     input  logic       clk
    ,input  logic       arst_n
    ,input  logic       rx_in_valid
    ,input  logic       rx_out_valid
    ,input  axis_beat_t tx_out
    ,input  logic       tx_out_valid
    ,input  logic       tx_out_ready
);

    int   fail_count = 0;
    logic in_pkt;
    logic pkt_tag;

    // tag of the tx_out packet in flight
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            in_pkt  <= 1'b0;
            pkt_tag <= 1'b0;
        end else if (tx_out_valid && tx_out_ready) begin
            in_pkt  <= ~tx_out.last;
            pkt_tag <= tx_out.user[3];
        end
    end

    tx_out_stable_a: assert property (@(posedge clk) disable iff (!arst_n)
        (tx_out_valid && !tx_out_ready) |=> (tx_out_valid && $stable(tx_out)))
    else begin
        fail_count++;
        $error("tx_out changed while tx_out_ready was low");
    end

    rx_out_gated_a: assert property (@(posedge clk)
        !rx_in_valid |-> !rx_out_valid)
    else begin
        fail_count++;
        $error("rx_out_valid high without rx_in_valid");
    end

    tx_idle_in_reset_a: assert property (@(posedge clk)
        !arst_n |-> !tx_out_valid)
    else begin
        fail_count++;
        $error("tx_out_valid high during reset");
    end

    tx_packet_tag_a: assert property (@(posedge clk) disable iff (!arst_n)
        (tx_out_valid && tx_out_ready && in_pkt) |-> (tx_out.user[3] == pkt_tag))
    else begin
        fail_count++;
        $error("tx_out packet interleaved with the other source");
    end

endmodule

bind slr_shell_top slr_shell_properties props (
     .clk           (clk            )
    ,.arst_n        (arst_n         )
    ,.rx_in_valid   (rx_in_valid    )
    ,.rx_out_valid  (rx_out_valid   )
    ,.tx_out        (tx_out         )
    ,.tx_out_valid  (tx_out_valid   )
    ,.tx_out_ready  (tx_out_ready   )
);

/* test/slr_shell_tb.sv */
`timescale 1ns/100ps

module slr_shell_tb import slr_shell_pkg::*; ();

    localparam int PKT_COUNT     = 40;
    localparam int BEAT_TIMEOUT  = 200;
    localparam int FILL_TIMEOUT  = 100;
    localparam int DRAIN_TIMEOUT = 2000;
    localparam int STALL_START   = 120;

    logic       clk;
    logic       arst_n;

    axis_beat_t rx_in;
    logic       rx_in_valid;
    logic       rx_in_ready;
    axis_beat_t rx_out;
    logic       rx_out_valid;
    logic       rx_out_ready;

    axis_beat_t tx_in;
    logic       tx_in_valid;
    logic       tx_in_ready;
    axis_beat_t tx_out;
    logic       tx_out_valid;
    logic       tx_out_ready;

    int errors   = 0;
    int timeouts = 0;
    bit hold_tx  = 1'b0;
    bit drain    = 1'b0;

    // beats in the order they were offered, one queue per destination
    axis_beat_t rx_expect_q[$];
    axis_beat_t loop_expect_q[$];
    axis_beat_t tx_expect_q[$];
    int         tag_packets[2];

    slr_shell_top dut (
         .clk           (clk            )
        ,.arst_n        (arst_n         )
        ,.rx_in         (rx_in          )
        ,.rx_in_valid   (rx_in_valid    )
        ,.rx_in_ready   (rx_in_ready    )
        ,.rx_out        (rx_out         )
        ,.rx_out_valid  (rx_out_valid   )
        ,.rx_out_ready  (rx_out_ready   )
        ,.tx_in         (tx_in          )
        ,.tx_in_valid   (tx_in_valid    )
        ,.tx_in_ready   (tx_in_ready    )
        ,.tx_out        (tx_out         )
        ,.tx_out_valid  (tx_out_valid   )
        ,.tx_out_ready  (tx_out_ready   )
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // user bit 3 tags the source, bits 2..0 count beats per source
    function automatic axis_beat_t make_beat(input logic tag, input logic [2:0] seq,
                                             input logic last);
        axis_beat_t beat;
        beat.data = {$urandom(), $urandom()};
        beat.keep = KEEP_W'($urandom());
        beat.user = {tag, seq};
        beat.last = last;
        return beat;
    endfunction

    task automatic check_beat(input string name, input axis_beat_t expected,
                              input axis_beat_t actual);
        assert (actual == expected) else begin
            errors++;
            $display("mismatch %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic wait_for_accept(input bit is_rx);
        int waited;
        bit taken;
        waited = 0;
        taken  = 1'b0;
        while (!taken && waited < BEAT_TIMEOUT) begin
            @(negedge clk);
            taken = is_rx ? rx_in_ready : tx_in_ready;
            waited++;
            @(posedge clk);
            #1;
        end
        if (!taken) begin
            timeouts++;
            $display("timeout: %s beat not accepted within %0d cycles",
                     is_rx ? "rx_in" : "tx_in", BEAT_TIMEOUT);
        end
    endtask

    task automatic drive_packets(input bit is_rx);
        axis_beat_t beat;
        int         len;
        int         gap;
        logic [2:0] seq;
        seq = '0;
        for (int p = 0; p < PKT_COUNT; p++) begin
            len = $urandom_range(1, 5);
            for (int b = 0; b < len; b++) begin
                gap = 0;
                if ($urandom_range(0, 2) == 0) begin
                    gap = $urandom_range(1, 4);
                end
                if (gap > 0) begin
                    if (is_rx) begin
                        rx_in_valid = 1'b0;
                    end else begin
                        tx_in_valid = 1'b0;
                    end
                    repeat (gap) begin
                        @(posedge clk);
                        #1;
                    end
                end
                beat = make_beat(is_rx, seq, b == len - 1);
                seq  = seq + 1'b1;
                if (is_rx) begin
                    rx_expect_q.push_back(beat);
                    loop_expect_q.push_back(beat);
                    rx_in       = beat;
                    rx_in_valid = 1'b1;
                end else begin
                    tx_expect_q.push_back(beat);
                    tx_in       = beat;
                    tx_in_valid = 1'b1;
                end
                wait_for_accept(is_rx);
            end
        end
        if (is_rx) begin
            rx_in_valid = 1'b0;
        end else begin
            tx_in_valid = 1'b0;
        end
    endtask

    // random back-pressure with occasional long stalls
    task automatic drive_ready();
        int rx_hold;
        int tx_hold;
        rx_hold = 0;
        tx_hold = 0;
        forever begin
            @(posedge clk);
            #1;
            if (drain) begin
                rx_out_ready = 1'b1;
                tx_out_ready = 1'b1;
            end else if (hold_tx) begin
                rx_out_ready = 1'b1;
                tx_out_ready = 1'b0;
            end else begin
                if (rx_hold > 0) begin
                    rx_hold--;
                    rx_out_ready = 1'b0;
                end else begin
                    if ($urandom_range(0, 39) == 0) begin
                        rx_hold = $urandom_range(10, 25);
                    end
                    rx_out_ready = ($urandom_range(0, 4) != 0);
                end
                if (tx_hold > 0) begin
                    tx_hold--;
                    tx_out_ready = 1'b0;
                end else begin
                    if ($urandom_range(0, 29) == 0) begin
                        tx_hold = $urandom_range(15, 30);
                    end
                    tx_out_ready = ($urandom_range(0, 3) != 0);
                end
            end
        end
    endtask

    // tx_out held off until the 8 crossing beats and the output register fill
    task automatic run_stall_phase();
        int waited;
        bit filled;
        waited = 0;
        filled = 1'b0;
        repeat (STALL_START) @(posedge clk);
        hold_tx = 1'b1;
        while (!filled && waited < FILL_TIMEOUT) begin
            @(negedge clk);
            filled = !rx_in_ready;
            waited++;
        end
        if (!filled) begin
            timeouts++;
            $display("timeout: rx_in_ready stayed high through %0d cycles of tx_out stall",
                     FILL_TIMEOUT);
        end
        repeat (20) @(posedge clk);
        hold_tx = 1'b0;
    endtask

    // transfers seen mid-cycle happen on the next rising edge
    initial begin : monitor
        axis_beat_t expected;
        logic       took0;
        logic       took1;
        logic       src;
        logic       exp_src;
        logic       src_last;
        logic       tag;
        logic       arb_locked;
        logic       arb_src;
        logic       arb_last;
        logic       pkt_open;
        logic       pkt_tag;
        bit         input_seen;
        arb_locked = 1'b0;
        arb_src    = 1'b0;
        arb_last   = 1'b1;
        pkt_open   = 1'b0;
        pkt_tag    = 1'b0;
        input_seen = 1'b0;
        forever begin
            @(negedge clk);
            if (arst_n) begin
                assert ((rx_out_valid && rx_out_ready) == (rx_in_valid && rx_in_ready)) else begin
                    errors++;
                    $display("mismatch rx_fanout expected %b actual %b",
                             rx_in_valid && rx_in_ready, rx_out_valid && rx_out_ready);
                end
                if (rx_out_valid && rx_out_ready) begin
                    if (rx_expect_q.size() == 0) begin
                        errors++;
                        $display("rx_out sent a beat that was never offered on rx_in");
                    end else begin
                        expected = rx_expect_q.pop_front();
                        check_beat("rx_bypass", expected, rx_out);
                    end
                end

                if (!input_seen) begin
                    assert (!tx_out_valid) else begin
                        errors++;
                        $display("tx_out_valid went high before any beat reached the arbiter");
                    end
                end

                // round robin reference, input 0 first after reset
                took0 = tx_in_valid && tx_in_ready;
                took1 = dut.cross_out_valid && dut.cross_out_ready;
                if (took0 || took1) begin
                    src = took1;
                    if (arb_locked) begin
                        exp_src = arb_src;
                    end else if (tx_in_valid && dut.cross_out_valid) begin
                        exp_src = ~arb_last;
                    end else begin
                        exp_src = dut.cross_out_valid;
                    end
                    assert (src == exp_src) else begin
                        errors++;
                        $display("mismatch tx_arb_grant expected %0d actual %0d", exp_src, src);
                    end
                    src_last   = src ? dut.cross_out.last : tx_in.last;
                    arb_last   = src;
                    arb_src    = src;
                    arb_locked = ~src_last;
                    input_seen = 1'b1;
                end

                if (tx_out_valid && tx_out_ready) begin
                    tag = tx_out.user[3];
                    if (pkt_open) begin
                        assert (tag == pkt_tag) else begin
                            errors++;
                            $display("mismatch tx_packet_tag expected %0d actual %0d", pkt_tag, tag);
                        end
                    end
                    if (tag && loop_expect_q.size() > 0) begin
                        expected = loop_expect_q.pop_front();
                        check_beat("tx_loopback", expected, tx_out);
                    end else if (!tag && tx_expect_q.size() > 0) begin
                        expected = tx_expect_q.pop_front();
                        check_beat("tx_bypass", expected, tx_out);
                    end else begin
                        errors++;
                        $display("tx_out sent a beat with tag %0d while none was pending", tag);
                    end
                    pkt_open = ~tx_out.last;
                    pkt_tag  = tag;
                    if (tx_out.last) begin
                        tag_packets[tag]++;
                    end
                end
            end
        end
    end

    initial begin
        int waited;
        bit drained;
        int prop_fails;
        void'($urandom(32'hd55));
        arst_n         = 1'b0;
        rx_in          = '0;
        rx_in_valid    = 1'b0;
        rx_out_ready   = 1'b0;
        tx_in          = '0;
        tx_in_valid    = 1'b0;
        tx_out_ready   = 1'b0;
        tag_packets[0] = 0;
        tag_packets[1] = 0;
        repeat (4) @(posedge clk);
        #1;
        arst_n = 1'b1;

        fork
            drive_ready();
        join_none
        fork
            drive_packets(1'b1);
            drive_packets(1'b0);
            run_stall_phase();
        join

        @(posedge clk);
        drain   = 1'b1;
        waited  = 0;
        drained = 1'b0;
        while (!drained && waited < DRAIN_TIMEOUT) begin
            @(negedge clk);
            drained = (rx_expect_q.size() == 0) && (loop_expect_q.size() == 0) &&
                      (tx_expect_q.size() == 0) && !tx_out_valid;
            waited++;
        end
        if (!drained) begin
            timeouts++;
            $display("timeout: tx_out did not drain, %0d loopback and %0d bypass beats left",
                     loop_expect_q.size(), tx_expect_q.size());
        end
        for (int t = 0; t < 2; t++) begin
            if (tag_packets[t] == 0) begin
                errors++;
                $display("no complete tx_out packet with tag %0d was seen", t);
            end
        end

        prop_fails = dut.props.fail_count;
        $display("errors: %0d mismatches, %0d timeouts, %0d property failures",
                 errors, timeouts, prop_fails);
        if (errors == 0 && timeouts == 0 && prop_fails == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* tx_arb_mux/tx_arb_mux.sv */
`timescale 1ns/100ps

module tx_arb_mux import slr_shell_pkg::*; (
     input  logic       clk
    ,input  logic       arst_n

    // input 0
    ,input  axis_beat_t bypass_beat
    ,input  logic       bypass_valid
    ,output logic       bypass_ready

    // input 1
    ,input  axis_beat_t app_beat
    ,input  logic       app_valid
    ,output logic       app_ready

    ,output axis_beat_t out_beat
    ,output logic       out_valid
    ,input  logic       out_ready
);

    arb_state_e state;
    logic       grant;
    logic       last_winner;

    logic       pick;
    logic       cur_sel;
    axis_beat_t cur_beat;
    logic       cur_valid;
    logic       load_en;
    logic       take;

    // round robin between packets, input 0 first after reset
    always_comb begin
        if (bypass_valid && app_valid) begin
            pick = ~last_winner;
        end else begin
            pick = app_valid;
        end
    end

    // a locked packet keeps its source until last
    assign cur_sel = (state == ARB_LOCKED) ? grant : pick;

    always_comb begin
        if (cur_sel) begin
            cur_beat  = app_beat;
            cur_valid = app_valid;
        end else begin
            cur_beat  = bypass_beat;
            cur_valid = bypass_valid;
        end
    end

    // output register empty or draining this cycle
    assign load_en = ~out_valid | out_ready;
    assign take    = load_en & cur_valid;

    assign bypass_ready = load_en & ~cur_sel;
    assign app_ready    = load_en & cur_sel;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= ARB_IDLE;
            grant       <= 1'b0;
            last_winner <= 1'b1;
            out_valid   <= 1'b0;
        end else begin
            if (take) begin
                out_valid   <= 1'b1;
                grant       <= cur_sel;
                last_winner <= cur_sel;
                if (cur_beat.last) begin
                    state <= ARB_IDLE;
                end else begin
                    state <= ARB_LOCKED;
                end
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            out_beat <= cur_beat;
        end
    end

endmodule

/* verilog/axis_fifo.sv */
`timescale 1ns/100ps

module axis_fifo import slr_shell_pkg::*; (
     input  logic       clk
    ,input  logic       arst_n

    ,input  axis_beat_t wr_beat
    ,input  logic       wr_valid
    ,output logic       wr_ready

    ,output axis_beat_t rd_beat
    ,output logic       rd_valid
    ,input  logic       rd_ready
);

    axis_beat_t                mem [FIFO_DEPTH];
    logic [FIFO_LOG_DEPTH-1:0] wr_ptr;
    logic [FIFO_LOG_DEPTH-1:0] rd_ptr;
    logic [FIFO_LOG_DEPTH:0]   count;

    logic full;
    logic empty;
    logic wr_en;
    logic rd_en;

    // count never exceeds the depth, so its top bit alone means full
    assign full  = count[FIFO_LOG_DEPTH];
    assign empty = (count == '0);

    assign wr_ready = ~full;
    assign rd_valid = ~empty;
    assign rd_beat  = mem[rd_ptr];

    assign wr_en = wr_valid & ~full;
    assign rd_en = rd_valid & rd_ready;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_beat;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* verilog/slr_shell_top.sv */
`timescale 1ns/100ps

module slr_shell_top import slr_shell_pkg::*; (
     input  logic       clk
    ,input  logic       arst_n

    // network receive
    ,input  axis_beat_t rx_in
    ,input  logic       rx_in_valid
    ,output logic       rx_in_ready

    // receive bypass
    ,output axis_beat_t rx_out
    ,output logic       rx_out_valid
    ,input  logic       rx_out_ready

    // external transmit
    ,input  axis_beat_t tx_in
    ,input  logic       tx_in_valid
    ,output logic       tx_in_ready

    // merged transmit
    ,output axis_beat_t tx_out
    ,output logic       tx_out_valid
    ,input  logic       tx_out_ready
);

    logic       cross_in_valid;
    logic       cross_in_ready;

    axis_beat_t cross_out;
    logic       cross_out_valid;
    logic       cross_out_ready;

    // both copies of a receive beat go together or not at all
    assign rx_in_ready    = rx_out_ready & cross_in_ready;
    assign rx_out         = rx_in;
    assign rx_out_valid   = rx_in_valid & rx_in_ready;
    assign cross_in_valid = rx_in_valid & rx_in_ready;

    slr_crossing crossing (
         .clk       (clk                )
        ,.arst_n    (arst_n             )

        ,.in_beat   (rx_in              )
        ,.in_valid  (cross_in_valid     )
        ,.in_ready  (cross_in_ready     )

        ,.out_beat  (cross_out          )
        ,.out_valid (cross_out_valid    )
        ,.out_ready (cross_out_ready    )
    );

    // transmit bypass on input 0, loopback on input 1
    tx_arb_mux tx_mux (
         .clk           (clk                )
        ,.arst_n        (arst_n             )

        ,.bypass_beat   (tx_in              )
        ,.bypass_valid  (tx_in_valid        )
        ,.bypass_ready  (tx_in_ready        )

        ,.app_beat      (cross_out          )
        ,.app_valid     (cross_out_valid    )
        ,.app_ready     (cross_out_ready    )

        ,.out_beat      (tx_out             )
        ,.out_valid     (tx_out_valid       )
        ,.out_ready     (tx_out_ready       )
    );

endmodule
